/* ex_forward_unit.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module ex_forward_unit (
    input  logic                   i_ex_mem_reg_write,
    input  logic [`REG_ADDR_W-1:0] i_ex_mem_rd,
    input  logic                   i_mem_wb_reg_write,
    input  logic [`REG_ADDR_W-1:0] i_mem_wb_rd,
    input  logic [`REG_ADDR_W-1:0] i_rs,
    input  logic [`REG_ADDR_W-1:0] i_rt,
    output pipe_pkg::fwd_sel_e     o_fwd_a,
    output pipe_pkg::fwd_sel_e     o_fwd_b
);

    import pipe_pkg::*;

    // Younger result wins, so EX/MEM is checked first
    function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] src);
        if (i_ex_mem_reg_write && (src == i_ex_mem_rd))
            return FWD_EX_MEM;
        else if (i_mem_wb_reg_write && (src == i_mem_wb_rd))
            return FWD_MEM_WB;
        else
            return FWD_NONE;
    endfunction

    always_comb
    begin
        o_fwd_a = pick_src(i_rs);
        o_fwd_b = pick_src(i_rt);
    end

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module ex_stage (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pipe_pkg::id_ex_t i_id_ex,
    input  pipe_pkg::wb_t    i_mem_wb,
    output pipe_pkg::wb_t    o_ex_mem
);

    import pipe_pkg::*;

    fwd_sel_e         fwd_a;
    fwd_sel_e         fwd_b;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b_fwd;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;

    ex_forward_unit u_ex_forward_unit (
        .i_ex_mem_reg_write (o_ex_mem.reg_write),
        .i_ex_mem_rd        (o_ex_mem.rd),
        .i_mem_wb_reg_write (i_mem_wb.reg_write),
        .i_mem_wb_rd        (i_mem_wb.rd),
        .i_rs               (i_id_ex.rs),
        .i_rt               (i_id_ex.rt),
        .o_fwd_a            (fwd_a),
        .o_fwd_b            (fwd_b)
    );

    ////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] ex_mem_val,
        input logic [`XLEN-1:0] mem_wb_val
    );
        case (sel)
            FWD_EX_MEM: return ex_mem_val;
            FWD_MEM_WB: return mem_wb_val;
            default:    return reg_val;
        endcase
    endfunction

    always_comb
    begin
        op_a     = fwd_mux(fwd_a, i_id_ex.rs_val, o_ex_mem.data, i_mem_wb.data);
        op_b_fwd = fwd_mux(fwd_b, i_id_ex.rt_val, o_ex_mem.data, i_mem_wb.data);
        // I-type takes the immediate in place of rt
        op_b     = i_id_ex.use_imm ? i_id_ex.imm_val : op_b_fwd;
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb
    begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_result = '0;
        endcase
    end

    // EX/MEM register, also the one-ahead forwarding source
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_ex_mem <= '0;
        else
        begin
            o_ex_mem.reg_write <= i_id_ex.reg_write;
            o_ex_mem.rd        <= i_id_ex.rd;
            o_ex_mem.data      <= alu_result;
        end
    end

endmodule

/* id_stage.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module id_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_valid,
    input  pipe_pkg::instr_u       i_instr,
    input  logic [`XLEN-1:0]       i_rs_val,
    input  logic [`XLEN-1:0]       i_rt_val,
    output logic [`REG_ADDR_W-1:0] o_rs_addr,
    output logic [`REG_ADDR_W-1:0] o_rt_addr,
    output pipe_pkg::id_ex_t       o_id_ex
);

    import pipe_pkg::*;

    logic                   legal;
    logic                   use_imm;
    alu_op_e                alu_op;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       imm_sext;
    logic [`XLEN-1:0]       imm_zext;
    logic [`XLEN-1:0]       imm_val;

    // rs and rt sit at the same bits in both formats
    assign o_rs_addr = i_instr.i.rs;
    assign o_rt_addr = i_instr.i.rt;

    assign imm_sext = {{(`XLEN-16){i_instr.i.imm[15]}}, i_instr.i.imm};
    assign imm_zext = {{(`XLEN-16){1'b0}}, i_instr.i.imm};

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    always_comb
    begin
        legal   = 1'b1;
        use_imm = 1'b0;
        alu_op  = ALU_ADD;
        dest    = i_instr.r.rd;
        imm_val = imm_sext;
        case (i_instr.r.opcode)
            `OP_RTYPE:
            begin
                case (i_instr.r.funct)
                    `FN_ADD: alu_op = ALU_ADD;
                    `FN_SUB: alu_op = ALU_SUB;
                    `FN_AND: alu_op = ALU_AND;
                    `FN_OR:  alu_op = ALU_OR;
                    `FN_XOR: alu_op = ALU_XOR;
                    `FN_SLT: alu_op = ALU_SLT;
                    default: legal  = 1'b0;
                endcase
            end
            `OP_ADDI:
            begin
                use_imm = 1'b1;
                dest    = i_instr.i.rt;
            end
            `OP_ANDI:
            begin
                use_imm = 1'b1;
                alu_op  = ALU_AND;
                dest    = i_instr.i.rt;
                imm_val = imm_zext;
            end
            `OP_ORI:
            begin
                use_imm = 1'b1;
                alu_op  = ALU_OR;
                dest    = i_instr.i.rt;
                imm_val = imm_zext;
            end
            default: legal = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_id_ex <= '0;
        else
        begin
            // Bubbles, illegal words and r0 targets never write
            o_id_ex.reg_write <= i_instr_valid && legal && (dest != '0);
            o_id_ex.alu_op    <= alu_op;
            o_id_ex.use_imm   <= use_imm;
            o_id_ex.rs        <= i_instr.i.rs;
            o_id_ex.rt        <= i_instr.i.rt;
            o_id_ex.rd        <= dest;
            o_id_ex.rs_val    <= i_rs_val;
            o_id_ex.rt_val    <= i_rt_val;
            o_id_ex.imm_val   <= imm_val;
        end
    end

endmodule

/* mem_wb_stage.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module mem_wb_stage (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  pipe_pkg::wb_t i_ex_mem,
    output pipe_pkg::wb_t o_mem_wb
);

    import pipe_pkg::*;

    ////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////

    // No data memory, the ALU result passes straight through
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_mem_wb <= '0;
        else
        begin
            o_mem_wb.reg_write <= i_ex_mem.reg_write;
            o_mem_wb.rd        <= i_ex_mem.rd;
            o_mem_wb.data      <= i_ex_mem.data;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // A write strobe arriving from EX always names a real register
    a_wr_rd_nonzero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_ex_mem.reg_write |-> (i_ex_mem.rd != '0)
    );

endmodule

/* pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Datapath and register file widths
`define XLEN        32
`define REG_ADDR_W  5

// Forwarding mux select width
`define FWD_SEL_W   3

// Major opcodes
`define OP_RTYPE    6'b000000
`define OP_ADDI     6'b001000
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101

// R-type function codes
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_SLT      6'b101010

`endif

/* pipe_pkg.sv */
`include "pipe_defines.svh"

package pipe_pkg;

    ////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    // One fetched word, seen as R-type or I-type
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    ////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [`FWD_SEL_W-1:0] {
        FWD_NONE   = `FWD_SEL_W'd0,
        FWD_EX_MEM = `FWD_SEL_W'd1,
        FWD_MEM_WB = `FWD_SEL_W'd2
    } fwd_sel_e;

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    typedef struct packed {
        logic                   reg_write;
        alu_op_e                alu_op;
        logic                   use_imm;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs_val;
        logic [`XLEN-1:0]       rt_val;
        logic [`XLEN-1:0]       imm_val;
    } id_ex_t;

    // Shared by EX/MEM and MEM/WB
    typedef struct packed {
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

/* pipe_top.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module pipe_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_valid,
    input  pipe_pkg::instr_u       i_instr,
    output logic                   o_wb_valid,
    output logic [`REG_ADDR_W-1:0] o_wb_rd,
    output logic [`XLEN-1:0]       o_wb_data
);

    import pipe_pkg::*;

    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`XLEN-1:0]       rs_val;
    logic [`XLEN-1:0]       rt_val;
    id_ex_t                 id_ex;
    wb_t                    ex_mem;
    wb_t                    mem_wb;

    id_stage u_id_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_rs_val      (rs_val),
        .i_rt_val      (rt_val),
        .o_rs_addr     (rs_addr),
        .o_rt_addr     (rt_addr),
        .o_id_ex       (id_ex)
    );

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .i_wb      (mem_wb),
        .o_rs_val  (rs_val),
        .o_rt_val  (rt_val)
    );

    ex_stage u_ex_stage (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex),
        .i_mem_wb (mem_wb),
        .o_ex_mem (ex_mem)
    );

    mem_wb_stage u_mem_wb_stage (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb)
    );

    // Write-back port mirrors the register file write
    assign o_wb_valid = mem_wb.reg_write;
    assign o_wb_rd    = mem_wb.rd;
    assign o_wb_data  = mem_wb.data;

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module reg_file (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`REG_ADDR_W-1:0] i_rs_addr,
    input  logic [`REG_ADDR_W-1:0] i_rt_addr,
    input  pipe_pkg::wb_t          i_wb,
    output logic [`XLEN-1:0]       o_rs_val,
    output logic [`XLEN-1:0]       o_rt_val
);

    import pipe_pkg::*;

    localparam int DEPTH = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [DEPTH];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int k = 0; k < DEPTH; k++)
                regs[k] <= '0;
        end
        else if (i_wb.reg_write)
            regs[i_wb.rd] <= i_wb.data;
    end

    // r0 reads zero, a matching write in progress is passed through
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (i_wb.reg_write && (i_wb.rd == addr))
            return i_wb.data;
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        o_rs_val = read_port(i_rs_addr);
        o_rt_val = read_port(i_rt_addr);
    end

    // Decode filters r0 targets, so none reach the write port
    a_no_r0_write: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wb.reg_write |-> (i_wb.rd != '0)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_pipe_top \
    --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log \
    && { echo "Simulation reported failures, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* sim.f */
+incdir+.
pipe_pkg.sv
id_stage.sv
reg_file.sv
ex_forward_unit.sv
ex_stage.sv
mem_wb_stage.sv
pipe_top.sv
tb_pipe_top.sv

/* tb_pipe_top.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module tb_pipe_top;

    import pipe_pkg::*;

    // Reset, directed slots with drains, random stream with worst-case bubbles, margin
    localparam int RST_CYCLES     = 10;
    localparam int DIRECTED_SLOTS = 70;
    localparam int RANDOM_INSTRS  = 200;
    localparam int MAX_CYCLES     = RST_CYCLES + DIRECTED_SLOTS + 2 * RANDOM_INSTRS + 4 + 50;

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    logic                   i_instr_valid;
    instr_u                 i_instr;
    logic                   o_wb_valid;
    logic [`REG_ADDR_W-1:0] o_wb_rd;
    logic [`XLEN-1:0]       o_wb_data;

    logic [`XLEN-1:0]                  model_regs [32];
    logic [`REG_ADDR_W+`XLEN-1:0]      exp_q [$];
    int                                err_count = 0;
    int                                check_count = 0;
    int                                cycle_count = 0;

    pipe_top u_pipe_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

    always #4 i_clk = ~i_clk;

    ////////////////////////////////////////
    // Watchdog and write-back monitor
    ////////////////////////////////////////

    always @(posedge i_clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Checks: %0d, errors: %0d", check_count, err_count + 1);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge i_clk)
    begin
        logic [`REG_ADDR_W-1:0] exp_rd;
        logic [`XLEN-1:0]       exp_data;
        if (i_rst_n && o_wb_valid)
        begin
            check_count++;
            if (exp_q.size() == 0)
            begin
                err_count++;
                $display("Unexpected write-back at %0t to r%0d with %h", $time, o_wb_rd,
                         o_wb_data);
            end
            else
            begin
                {exp_rd, exp_data} = exp_q.pop_front();
                if (o_wb_rd != exp_rd)
                begin
                    err_count++;
                    $display("Fail at %0t: o_wb_rd expected %0d, got %0d", $time, exp_rd,
                             o_wb_rd);
                end
                if (o_wb_data != exp_data)
                begin
                    err_count++;
                    $display("Fail at %0t: o_wb_data expected %h, got %h", $time, exp_data,
                             o_wb_data);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Encoding and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] r_type_word(input logic [5:0] fn, input logic [4:0] rd,
                                                input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] op, input logic [4:0] rt,
                                                input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Executes one word in program order and queues its write-back
    task automatic model_step(input logic [31:0] w);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        bit          legal;
        rs    = w[25:21];
        rt    = w[20:16];
        rd    = w[15:11];
        a     = model_regs[rs];
        b     = model_regs[rt];
        res   = '0;
        legal = 1'b1;
        case (w[31:26])
            `OP_RTYPE:
            begin
                case (w[5:0])
                    `FN_ADD: res = a + b;
                    `FN_SUB: res = a - b;
                    `FN_AND: res = a & b;
                    `FN_OR:  res = a | b;
                    `FN_XOR: res = a ^ b;
                    `FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: legal = 1'b0;
                endcase
            end
            `OP_ADDI:
            begin
                rd  = rt;
                res = a + {{16{w[15]}}, w[15:0]};
            end
            `OP_ANDI:
            begin
                rd  = rt;
                res = a & {16'h0000, w[15:0]};
            end
            `OP_ORI:
            begin
                rd  = rt;
                res = a | {16'h0000, w[15:0]};
            end
            default: legal = 1'b0;
        endcase
        if (legal && (rd != 5'd0))
        begin
            model_regs[rd] = res;
            exp_q.push_back({rd, res});
        end
    endtask

    ////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////

    task automatic issue(input logic [31:0] w);
        @(negedge i_clk);
        i_instr_valid = 1'b1;
        i_instr       = w;
        model_step(w);
    endtask

    // Valid low with an arbitrary word on the bus
    task automatic hold_invalid(input logic [31:0] w);
        @(negedge i_clk);
        i_instr_valid = 1'b0;
        i_instr       = w;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) hold_invalid($urandom);
    endtask

    task automatic drain_and_check(input string name);
        idle_cycles(4);
        check_count++;
        if (exp_q.size() != 0)
        begin
            err_count++;
            $display("%s: %0d expected write-backs never appeared", name, exp_q.size());
            exp_q.delete();
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_independent();
        issue(i_type_word(`OP_ADDI, 5'd1, 5'd0, 16'hfffb));
        issue(i_type_word(`OP_ORI, 5'd3, 5'd0, 16'h8001));
        issue(i_type_word(`OP_ADDI, 5'd4, 5'd0, 16'h7fff));
        issue(i_type_word(`OP_ANDI, 5'd2, 5'd0, 16'hffff));
        drain_and_check("test_independent");
        // Zero extension on a negative source
        issue(i_type_word(`OP_ANDI, 5'd5, 5'd1, 16'h8f0f));
        issue(i_type_word(`OP_ORI, 5'd6, 5'd4, 16'h8000));
        drain_and_check("test_independent");
    endtask

    task automatic test_ex_mem_forward();
        issue(i_type_word(`OP_ADDI, 5'd7, 5'd0, 16'd100));
        issue(i_type_word(`OP_ADDI, 5'd8, 5'd0, 16'hfff9));
        issue(r_type_word(`FN_ADD, 5'd9, 5'd7, 5'd8));
        issue(r_type_word(`FN_SUB, 5'd9, 5'd9, 5'd8));
        // r9 sits in both EX/MEM and MEM/WB here
        issue(r_type_word(`FN_XOR, 5'd10, 5'd8, 5'd9));
        issue(r_type_word(`FN_SLT, 5'd11, 5'd10, 5'd9));
        issue(r_type_word(`FN_SLT, 5'd12, 5'd8, 5'd11));
        issue(r_type_word(`FN_ADD, 5'd13, 5'd12, 5'd12));
        drain_and_check("test_ex_mem_forward");
    endtask

    task automatic test_mem_wb_and_bypass();
        issue(i_type_word(`OP_ADDI, 5'd14, 5'd0, 16'h0055));
        idle_cycles(1);
        issue(r_type_word(`FN_ADD, 5'd15, 5'd14, 5'd0));
        issue(i_type_word(`OP_ADDI, 5'd16, 5'd0, 16'hfffd));
        idle_cycles(1);
        issue(r_type_word(`FN_SUB, 5'd17, 5'd0, 5'd16));
        // Three slots apart, only the register file bypass helps
        issue(i_type_word(`OP_ADDI, 5'd18, 5'd0, 16'h0123));
        idle_cycles(2);
        issue(r_type_word(`FN_OR, 5'd19, 5'd18, 5'd16));
        issue(i_type_word(`OP_ADDI, 5'd20, 5'd0, 16'h00f0));
        idle_cycles(2);
        issue(r_type_word(`FN_AND, 5'd21, 5'd19, 5'd20));
        drain_and_check("test_mem_wb_and_bypass");
    endtask

    task automatic test_reg_zero_and_bubbles();
        issue(i_type_word(`OP_ADDI, 5'd0, 5'd0, 16'd77));
        issue(r_type_word(`FN_ADD, 5'd22, 5'd0, 5'd0));
        issue(i_type_word(`OP_ORI, 5'd0, 5'd0, 16'hffff));
        idle_cycles(1);
        issue(r_type_word(`FN_OR, 5'd23, 5'd0, 5'd0));
        // Unknown opcode, then unknown funct
        issue({6'h3f, 5'd1, 5'd24, 16'h1234});
        issue(r_type_word(6'h01, 5'd25, 5'd1, 5'd1));
        hold_invalid(r_type_word(`FN_ADD, 5'd26, 5'd7, 5'd7));
        idle_cycles(3);
        issue(r_type_word(`FN_ADD, 5'd27, 5'd0, 5'd7));
        issue(r_type_word(`FN_ADD, 5'd28, 5'd1, 5'd0));
        drain_and_check("test_reg_zero_and_bubbles");
    endtask

    task automatic test_random_stream();
        int         kind;
        logic [5:0] fn;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        for (int n = 0; n < RANDOM_INSTRS; n++)
        begin
            kind = int'($urandom_range(0, 8));
            rs   = 5'($urandom_range(0, 7));
            rt   = 5'($urandom_range(0, 7));
            rd   = 5'($urandom_range(0, 7));
            case (kind)
                0:       fn = `FN_ADD;
                1:       fn = `FN_SUB;
                2:       fn = `FN_AND;
                3:       fn = `FN_OR;
                4:       fn = `FN_XOR;
                default: fn = `FN_SLT;
            endcase
            if (kind < 6)
                issue(r_type_word(fn, rd, rs, rt));
            else if (kind == 6)
                issue(i_type_word(`OP_ADDI, rt, rs, 16'($urandom)));
            else if (kind == 7)
                issue(i_type_word(`OP_ANDI, rt, rs, 16'($urandom)));
            else
                issue(i_type_word(`OP_ORI, rt, rs, 16'($urandom)));
            if ($urandom_range(0, 3) == 0)
                idle_cycles(1);
        end
        drain_and_check("test_random_stream");
    endtask

    initial
    begin
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        void'($urandom(32'h331f_4f67));
        for (int k = 0; k < 32; k++)
            model_regs[k] = '0;
        repeat (RST_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        test_independent();
        test_ex_mem_forward();
        test_mem_wb_and_bypass();
        test_reg_zero_and_bubbles();
        test_random_stream();

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
